// File: logic/i2c_defines.svh
`ifndef I2C_DEFINES_SVH
`define I2C_DEFINES_SVH

// SCL timing
`define I2C_HALF_PERIOD 8      // clk cycles per SCL half-period
`define I2C_DIV_W       16     // Half-period counter width

// Field widths
`define I2C_ADDR_W      10     // 10-bit slave address
`define I2C_DATA_W      8      // One data byte
`define I2C_CNT_W       4      // Bit counter covers 0 to 10

`endif

// File: logic/i2c_pkg.sv
`include "i2c_defines.svh"

package i2c_pkg;

    // Protocol sequencer states
    typedef enum logic [4:0] {
        ST_IDLE,        // Bus released and waiting for a request
        ST_START,       // SDA low while SCL high
        ST_ADDR_BIT,    // Address and R/W bits go out
        ST_ADDR_ACK,    // Slave acknowledges the address
        ST_WR_BIT,      // Write byte goes out
        ST_WR_ACK,      // Slave acknowledges the byte
        ST_RD_BIT,      // Read byte comes in
        ST_MNACK,       // Master answers NACK
        ST_STOP1,       // SCL low with SDA low
        ST_STOP2,       // SCL high with SDA low
        ST_STOP3        // SDA released for the stop edge
    } i2c_state_t;

    // Transfer direction, matches the R/W bit on the wire
    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } i2c_op_t;

    // Which shift register the current bit belongs to
    typedef enum logic [1:0] {
        PH_ADDR,
        PH_WRITE,
        PH_READ
    } i2c_phase_t;

    typedef logic [`I2C_ADDR_W-1:0] addr_t;   // Slave address
    typedef logic [`I2C_DATA_W-1:0] byte_t;   // Data byte

endpackage

// File: logic/i2c_line_if.sv
interface i2c_line_if;
    import i2c_pkg::*;

    logic       scl_rise;    // Low half-period ends here
    logic       scl_fall;    // High half-period ends here
    logic       sda_low;     // Sequencer wants SDA pulled low
    logic       shift_load;  // Load request or rearm counter for data
    logic       shift_next;  // Advance one bit
    i2c_phase_t phase;       // Active shift register
    logic       tx_bit;      // Bit now on offer
    logic       last_bit;    // Counter at zero
    logic       sda_sample;  // Synchronized SDA level

    modport gen (
        output scl_rise,
        output scl_fall
    );

    modport seq (
        input  scl_rise, scl_fall,
        input  tx_bit, last_bit, sda_sample,
        output sda_low, shift_load, shift_next, phase
    );

    modport shift (
        input  shift_load, shift_next, phase,
        output tx_bit, last_bit, sda_sample
    );

endinterface

// File: logic/i2c_scl_gen.sv
`include "i2c_defines.svh"

module i2c_scl_gen (
    input  logic    clk,
    input  logic    rst,
    input  logic    run,        // High for the whole transaction
    input  logic    scl_sense,  // Actual SCL level from the pad
    output logic    scl_pull,   // Pull SCL low
    i2c_line_if.gen line
);

    localparam int unsigned HALF_LAST = `I2C_HALF_PERIOD - 1;

    logic [`I2C_DIV_W-1:0] half_cnt;   // clk count inside a half-period
    logic                  scl_high;   // Target SCL level
    logic [1:0]            scl_sync;   // Two-flop synchronizer on SCL
    logic                  half_done;

    assign half_done = (half_cnt == HALF_LAST[`I2C_DIV_W-1:0]);

    // High phase waits for the line itself so a slave can stretch the clock
    assign line.scl_fall = scl_high && half_done && scl_sync[1];
    assign line.scl_rise = !scl_high && half_done;   // Low phase is ours alone

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            half_cnt <= '0;
            scl_high <= 1'b1;              // Released
        end else if (!run) begin
            half_cnt <= '0;                // Parked with SCL released
            scl_high <= 1'b1;
        end else if (line.scl_rise || line.scl_fall) begin
            half_cnt <= '0;
            scl_high <= !scl_high;         // Next half-period
        end else if (!half_done) begin
            half_cnt <= half_cnt + 1'b1;
        end
        // At terminal count the counter waits here while SCL is stretched
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scl_sync <= 2'b11;             // Bus idles high
        end else begin
            scl_sync <= {scl_sync[0], scl_sense};
        end
    end

    assign scl_pull = !scl_high;          // Straight from a flop so the pad never glitches

    // Both half-period ends in one cycle would skip a whole SCL phase
    a_strobe_excl: assert property (@(posedge clk) disable iff (rst)
        !(line.scl_rise && line.scl_fall));

endmodule

// File: logic/i2c_shifter.sv
`include "i2c_defines.svh"

module i2c_shifter (
    input  logic           clk,
    input  logic           rst,
    input  i2c_pkg::addr_t req_addr,   // Valid in the load cycle only
    input  logic           req_rw,
    input  i2c_pkg::byte_t req_data,
    input  logic           sda_sense,  // Actual SDA level from the pad
    output i2c_pkg::byte_t rx_byte,    // Last completed read byte
    i2c_line_if.shift      line
);
    import i2c_pkg::*;

    localparam int unsigned ADDR_TOP = `I2C_ADDR_W;       // 11 bits so 10 down to 0
    localparam int unsigned DATA_TOP = `I2C_DATA_W - 1;

    logic [`I2C_ADDR_W:0]   addr_sr;   // Address then R/W in the LSB
    byte_t                  data_sr;   // Outgoing byte
    byte_t                  rx_sr;     // Incoming byte
    byte_t                  rx_next;
    logic [`I2C_CNT_W-1:0]  bit_cnt;   // Bits left after the current one
    logic [1:0]             sda_sync;

    assign rx_next = {rx_sr[`I2C_DATA_W-2:0], sda_sync[1]};

    // Address word, outgoing byte and incoming byte
    always_ff @(posedge clk) begin
        if (line.shift_load && line.phase == PH_ADDR) begin
            addr_sr <= {req_addr, req_rw};
            data_sr <= req_data;
        end else if (line.shift_next) begin
            case (line.phase)
                PH_ADDR:  addr_sr <= {addr_sr[`I2C_ADDR_W-1:0], 1'b0};   // MSB first
                PH_WRITE: data_sr <= {data_sr[`I2C_DATA_W-2:0], 1'b0};
                default:  rx_sr   <= rx_next;                            // Sample at SCL fall
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_cnt  <= '0;
            sda_sync <= 2'b11;
            rx_byte  <= '0;
        end else begin
            sda_sync <= {sda_sync[0], sda_sense};
            if (line.shift_load) begin
                // Address load at request time and data rearm after the address ACK
                bit_cnt <= (line.phase == PH_ADDR) ? ADDR_TOP[`I2C_CNT_W-1:0]
                                                   : DATA_TOP[`I2C_CNT_W-1:0];
            end else if (line.shift_next && !line.last_bit) begin
                bit_cnt <= bit_cnt - 1'b1;
            end
            if (line.shift_next && line.phase == PH_READ && line.last_bit) begin
                rx_byte <= rx_next;        // Whole byte in
            end
        end
    end

    assign line.last_bit   = (bit_cnt == '0);
    assign line.tx_bit     = (line.phase == PH_WRITE) ? data_sr[`I2C_DATA_W-1]
                                                      : addr_sr[`I2C_ADDR_W];
    assign line.sda_sample = sda_sync[1];

    // A count past 10 means a load or shift strobe came out of order
    a_cnt_range: assert property (@(posedge clk) disable iff (rst)
        bit_cnt <= ADDR_TOP[`I2C_CNT_W-1:0]);

endmodule

// File: logic/i2c_sequencer.sv
module i2c_sequencer (
    input  logic    clk,
    input  logic    rst,
    input  logic    start,      // Request strobe
    input  logic    rw,         // Sampled with start
    output logic    busy,
    output logic    done,       // One cycle at the end
    output logic    ack_error,  // Address or data NACK seen
    output logic    run,        // Keeps the SCL generator going
    output logic    sda_pull,   // Pull SDA low
    i2c_line_if.seq line
);
    import i2c_pkg::*;

    i2c_state_t state;
    i2c_state_t state_nx;
    i2c_op_t    op;            // Direction latched at request time
    logic       accept;
    logic       nack_seen;

    assign accept    = (state == ST_IDLE) && start;   // Starts while busy fall through
    assign nack_seen = line.scl_fall && line.sda_sample &&
                       (state == ST_ADDR_ACK || state == ST_WR_ACK);

    // Next state moves only on SCL strobes
    always_comb begin
        state_nx        = state;
        line.shift_load = 1'b0;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    state_nx        = ST_START;
                    line.shift_load = 1'b1;            // Capture address word and byte
                end
            end
            ST_START: begin
                if (line.scl_fall) state_nx = ST_ADDR_BIT;
            end
            ST_ADDR_BIT: begin
                if (line.scl_fall && line.last_bit) state_nx = ST_ADDR_ACK;
            end
            ST_ADDR_ACK: begin
                if (line.scl_fall) begin
                    if (line.sda_sample) begin
                        state_nx = ST_STOP1;           // No slave at this address
                    end else begin
                        line.shift_load = 1'b1;        // Rearm counter for the byte
                        state_nx = (op == OP_READ) ? ST_RD_BIT : ST_WR_BIT;
                    end
                end
            end
            ST_WR_BIT: begin
                if (line.scl_fall && line.last_bit) state_nx = ST_WR_ACK;
            end
            ST_WR_ACK: begin
                if (line.scl_fall) state_nx = ST_STOP1;
            end
            ST_RD_BIT: begin
                if (line.scl_fall && line.last_bit) state_nx = ST_MNACK;
            end
            ST_MNACK: begin
                if (line.scl_fall) state_nx = ST_STOP1;
            end
            ST_STOP1: begin
                if (line.scl_rise) state_nx = ST_STOP2;
            end
            ST_STOP2: begin
                if (line.scl_fall) state_nx = ST_STOP3;
            end
            ST_STOP3: state_nx = ST_IDLE;
            default:  state_nx = ST_IDLE;
        endcase
    end

    // Every bit state advances its shift register at the end of SCL high
    assign line.shift_next = line.scl_fall &&
                             (state == ST_ADDR_BIT || state == ST_WR_BIT || state == ST_RD_BIT);

    always_comb begin
        case (state)
            ST_WR_BIT, ST_WR_ACK: line.phase = PH_WRITE;
            ST_RD_BIT, ST_MNACK:  line.phase = PH_READ;
            // During the address ACK the upcoming byte phase is selected
            ST_ADDR_ACK: line.phase = (op == OP_READ) ? PH_READ : PH_WRITE;
            default:     line.phase = PH_ADDR;
        endcase
    end

    always_comb begin
        case (state)
            ST_START, ST_STOP1, ST_STOP2: line.sda_low = 1'b1;
            ST_ADDR_BIT, ST_WR_BIT:       line.sda_low = !line.tx_bit;
            default:                      line.sda_low = 1'b0;   // Released and MNACK too
        endcase
    end

    // SCL must stay high after the stop so run drops in the same cycle as the last fall
    assign run = (state != ST_IDLE) && (state != ST_STOP3) &&
                 !(state == ST_STOP2 && line.scl_fall);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= ST_IDLE;
            op        <= OP_WRITE;
            busy      <= 1'b0;
            done      <= 1'b0;
            ack_error <= 1'b0;
            sda_pull  <= 1'b0;
        end else begin
            state    <= state_nx;
            busy     <= (state_nx != ST_IDLE);
            done     <= (state == ST_STOP3);   // Lines up with busy falling
            sda_pull <= line.sda_low;          // Registered pad drive
            if (accept) begin
                op        <= i2c_op_t'(rw);
                ack_error <= 1'b0;
            end else if (nack_seen) begin
                ack_error <= 1'b1;
            end
        end
    end

    // Idle with busy still up would block the next request
    a_idle_not_busy: assert property (@(posedge clk) disable iff (rst)
        (state == ST_IDLE) |-> !busy);

endmodule

// File: logic/i2c_master_top.sv
module i2c_master_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,       // Single-cycle request
    input  logic           rw,          // 1 reads
    input  i2c_pkg::addr_t slave_addr,
    input  i2c_pkg::byte_t data_in,
    inout  wire            scl,         // Open-drain
    inout  wire            sda,         // Open-drain
    output i2c_pkg::byte_t data_out,
    output logic           busy,
    output logic           done,
    output logic           ack_error
);

    logic run;
    logic scl_pull;
    logic sda_pull;

    i2c_line_if line ();

    i2c_scl_gen u_scl_gen (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .scl_sense (scl),       // Read back for stretching
        .scl_pull  (scl_pull),
        .line      (line.gen)
    );

    i2c_shifter u_shifter (
        .clk       (clk),
        .rst       (rst),
        .req_addr  (slave_addr),
        .req_rw    (rw),
        .req_data  (data_in),
        .sda_sense (sda),       // ACK and read data
        .rx_byte   (data_out),
        .line      (line.shift)
    );

    i2c_sequencer u_sequencer (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .rw        (rw),
        .busy      (busy),
        .done      (done),
        .ack_error (ack_error),
        .run       (run),
        .sda_pull  (sda_pull),
        .line      (line.seq)
    );

    // Low or released only since the pull-ups give the high level
    assign scl = scl_pull ? 1'b0 : 1'bz;
    assign sda = sda_pull ? 1'b0 : 1'bz;

endmodule

// File: bench/i2c_slave_model.sv
`include "i2c_defines.svh"

module i2c_slave_model (
    input  logic           clk,
    input  logic           rst,
    input  logic           clear,        // Forget what the last transaction left
    inout  wire            scl,
    inout  wire            sda,
    input  i2c_pkg::addr_t own_addr,
    input  i2c_pkg::byte_t rd_byte,      // Returned on a read
    input  logic           ack_data,     // Low answers the written byte with NACK
    input  logic [15:0]    stretch,      // clk cycles of SCL hold after the address ACK
    output i2c_pkg::addr_t rx_addr,
    output logic           rx_rw,
    output i2c_pkg::byte_t rx_data,
    output logic           rx_valid,     // Written byte arrived
    output logic           master_nack,  // SDA high in the ninth read clock
    output logic [7:0]     start_count
);
    import i2c_pkg::*;

    typedef enum logic [2:0] {S_IDLE, S_ADDR, S_AACK, S_WDATA, S_DACK, S_RDATA, S_MACK} slv_st_t;

    slv_st_t     state;
    logic        scl_q;
    logic        sda_q;
    logic [10:0] shreg;                  // Address and R/W, written byte in the low bits
    byte_t       rd_sr;                  // Read byte still to go out
    logic [3:0]  bit_cnt;
    logic        sda_drive;
    logic        scl_drive;
    logic [15:0] hold_left;
    logic        start_seen;
    logic        stop_seen;

    pullup (scl);                        // Bus pull-ups
    pullup (sda);
    assign scl = scl_drive ? 1'b0 : 1'bz;
    assign sda = sda_drive ? 1'b0 : 1'bz;

    assign start_seen = scl && scl_q && sda_q && !sda;   // SDA falls under SCL high
    assign stop_seen  = scl && scl_q && !sda_q && sda;   // SDA rises under SCL high

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= S_IDLE;
            scl_q       <= 1'b1;
            sda_q       <= 1'b1;
            shreg       <= '0;
            rd_sr       <= '0;
            bit_cnt     <= '0;
            sda_drive   <= 1'b0;
            scl_drive   <= 1'b0;
            hold_left   <= '0;
            rx_addr     <= '0;
            rx_rw       <= 1'b0;
            rx_data     <= '0;
            rx_valid    <= 1'b0;
            master_nack <= 1'b0;
            start_count <= '0;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            if (clear) begin
                rx_addr     <= '0;
                rx_rw       <= 1'b0;
                rx_valid    <= 1'b0;
                master_nack <= 1'b0;
                start_count <= '0;
            end
            if (hold_left != 16'd0) begin
                hold_left <= hold_left - 16'd1;
                if (hold_left == 16'd1) scl_drive <= 1'b0;   // Stretch over
            end
            if (start_seen) begin
                state       <= S_ADDR;
                bit_cnt     <= '0;
                sda_drive   <= 1'b0;
                start_count <= start_count + 8'd1;
            end else if (stop_seen) begin
                state     <= S_IDLE;
                sda_drive <= 1'b0;
            end else if (scl && !scl_q) begin                 // Rising SCL samples
                if (state == S_ADDR || state == S_WDATA) begin
                    shreg   <= {shreg[9:0], sda};
                    bit_cnt <= bit_cnt + 4'd1;
                end
                if (state == S_MACK) master_nack <= sda;
            end else if (!scl && scl_q) begin                 // Falling SCL drives
                case (state)
                    S_ADDR: begin
                        if (bit_cnt == 4'd11 && shreg[10:1] == own_addr) begin
                            rx_addr   <= shreg[10:1];
                            rx_rw     <= shreg[0];
                            sda_drive <= 1'b1;                // Address ACK
                            state     <= S_AACK;
                        end else if (bit_cnt == 4'd11) begin
                            state <= S_IDLE;                  // Not ours
                        end
                    end
                    S_AACK: begin
                        bit_cnt <= shreg[0] ? 4'd1 : 4'd0;
                        if (stretch != 16'd0) begin
                            scl_drive <= 1'b1;
                            hold_left <= stretch;
                        end
                        sda_drive <= shreg[0] && !rd_byte[7];
                        rd_sr     <= {rd_byte[6:0], 1'b0};
                        state     <= shreg[0] ? S_RDATA : S_WDATA;
                    end
                    S_WDATA: begin
                        if (bit_cnt == 4'd8) begin
                            rx_data   <= shreg[7:0];
                            rx_valid  <= 1'b1;
                            sda_drive <= ack_data;
                            state     <= S_DACK;
                        end
                    end
                    S_RDATA: begin
                        if (bit_cnt == 4'd8) begin
                            sda_drive <= 1'b0;                // Master answers next
                            state     <= S_MACK;
                        end else begin
                            sda_drive <= !rd_sr[7];
                            rd_sr     <= {rd_sr[6:0], 1'b0};
                            bit_cnt   <= bit_cnt + 4'd1;
                        end
                    end
                    S_DACK, S_MACK: begin
                        sda_drive <= 1'b0;
                        state     <= S_IDLE;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: bench/tb_i2c_master.sv
`include "i2c_defines.svh"

module tb_i2c_master;
    import i2c_pkg::*;

    localparam int CLK_HALF    = 5;
    localparam int T_DRIVE     = 1;                        // Input skew after the edge
    localparam int DONE_LIMIT  = 80 * `I2C_HALF_PERIOD + 256;
    localparam int TAIL_CYCLES = 4 * `I2C_HALF_PERIOD;

    logic        clk;
    logic        rst;
    logic        start;
    logic        rw;
    addr_t       slave_addr;
    byte_t       data_in;
    byte_t       data_out;
    logic        busy;
    logic        done;
    logic        ack_error;
    wire         scl;
    wire         sda;
    logic        clear;
    addr_t       own_addr;
    byte_t       rd_byte;
    logic        ack_data;
    logic [15:0] stretch;
    addr_t       rx_addr;
    logic        rx_rw;
    byte_t       rx_data;
    logic        rx_valid;
    logic        master_nack;
    logic [7:0]  start_count;
    logic [31:0] lfsr;
    int          test_errors;
    int          passed_tests;
    int          failed_tests;
    int          done_count;
    int          test_num;
    logic        timed_out;

    i2c_master_top dut0 (
        .clk(clk), .rst(rst), .start(start), .rw(rw), .slave_addr(slave_addr),
        .data_in(data_in), .scl(scl), .sda(sda), .data_out(data_out),
        .busy(busy), .done(done), .ack_error(ack_error)
    );

    i2c_slave_model u_slave (
        .clk(clk), .rst(rst), .clear(clear), .scl(scl), .sda(sda),
        .own_addr(own_addr), .rd_byte(rd_byte), .ack_data(ack_data), .stretch(stretch),
        .rx_addr(rx_addr), .rx_rw(rx_rw), .rx_data(rx_data), .rx_valid(rx_valid),
        .master_nack(master_nack), .start_count(start_count)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        repeat (n) begin
            lfsr  = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            value = {value[30:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("%s", what);
            test_errors++;
        end
    endtask

    task automatic step_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #T_DRIVE;
            if (done) done_count++;
        end
    endtask

    task automatic wait_done(output logic ok);
        int cycles;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < DONE_LIMIT) begin
            step_cycles(1);
            cycles++;
            ok = done;
        end
    endtask

    task automatic pulse_start();
        start = 1'b1;
        @(posedge clk);
        #T_DRIVE;
        start = 1'b0;
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            passed_tests++;
            $display("%s: ok", name);
        end else begin
            failed_tests++;
            $display("%s: %0d check(s) failed", name, test_errors);
        end
    endtask

    task automatic run_vector(input logic [31:0] v_op, input logic [31:0] v_req,
                              input logic [31:0] v_own, input logic [31:0] v_byte,
                              input logic [31:0] v_ack, input logic [31:0] v_stretch,
                              input logic [31:0] v_twice, input logic [31:0] v_err,
                              input logic [31:0] v_dout);
        logic        ok;
        logic        matched;
        logic [31:0] r;
        test_errors = 0;
        done_count  = 0;
        test_num++;
        matched  = (v_req[9:0] == v_own[9:0]);
        own_addr = v_own[9:0];
        rd_byte  = v_byte[7:0];
        ack_data = v_ack[0];
        if (v_stretch == 32'hff) begin
            take_bits(6, r);                               // 8 to 71 cycles
            stretch = 16'd8 + r[15:0];
        end else begin
            stretch = v_stretch[15:0];
        end
        rw         = v_op[0];
        slave_addr = v_req[9:0];
        data_in    = v_byte[7:0];
        clear      = 1'b1;
        step_cycles(1);
        clear = 1'b0;
        pulse_start();
        check_true(busy, "busy did not rise after start");
        if (v_twice[0]) begin
            step_cycles(3 * `I2C_HALF_PERIOD);
            rw         = !v_op[0];                        // Must not reach the bus
            slave_addr = ~v_req[9:0];
            pulse_start();
        end
        wait_done(ok);
        if (!ok) begin
            $display("Timed out waiting for done in test %0d", test_num);
            timed_out = 1'b1;
            test_errors++;
        end else begin
            check_value("busy", 32'(busy), 32'h0);
            check_value("ack_error", 32'(ack_error), v_err);
            step_cycles(TAIL_CYCLES);
            check_value("done pulses", 32'(done_count), 32'h1);
            check_value("ack_error", 32'(ack_error), v_err);
            check_value("data_out", 32'(data_out), v_dout);
            check_value("start_count", 32'(start_count), 32'h1);
            if (matched) begin
                check_value("rx_addr", 32'(rx_addr), 32'(v_req[9:0]));
                check_value("rx_rw", 32'(rx_rw), 32'(v_op[0]));
            end
            if (matched && !v_op[0]) begin
                check_true(rx_valid, "slave did not receive the written byte");
                check_value("rx_data", 32'(rx_data), 32'(v_byte[7:0]));
            end else begin
                check_true(!rx_valid, "slave received a byte it should not have");
            end
            if (matched && v_op[0]) check_true(master_nack, "master did not NACK the read byte");
            check_true(scl === 1'b1 && sda === 1'b1, "bus not released after the stop");
        end
        finish_test($sformatf("test %0d %s addr %h", test_num, v_op[0] ? "read" : "write",
                              v_req[9:0]));
    endtask

    initial begin
        int          fd;
        int          n;
        string       line_buf;
        logic [31:0] f[9];
        start = 1'b0;
        rw = 1'b0;
        slave_addr = '0;
        data_in = '0;
        clear = 1'b0;
        own_addr = '0;
        rd_byte = '0;
        ack_data = 1'b1;
        stretch = '0;
        lfsr = 32'hdbe110ee;
        test_errors = 0;
        passed_tests = 0;
        failed_tests = 0;
        done_count = 0;
        test_num = 0;
        timed_out = 1'b0;
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #T_DRIVE;
        rst = 1'b0;
        step_cycles(1);
        check_value("busy", 32'(busy), 32'h0);
        check_value("done", 32'(done), 32'h0);
        check_value("ack_error", 32'(ack_error), 32'h0);
        check_true(scl === 1'b1 && sda === 1'b1, "bus not released after reset");
        finish_test("reset");
        fd = $fopen("bench/i2c_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open bench/i2c_vectors.txt");
            failed_tests++;
        end else begin
            while (!timed_out && $fgets(line_buf, fd) != 0) begin
                if (line_buf.len() == 0 || line_buf.getc(0) == "#") continue;
                n = $sscanf(line_buf, "%h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
                if (n == 9) begin
                    run_vector(f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
                end else if (n > 0) begin
                    $display("Malformed vector line: %s", line_buf);
                    failed_tests++;
                end
            end
            $fclose(fd);
        end
        $display("%0d tests, %0d passed, %0d failed", passed_tests + failed_tests,
                 passed_tests, failed_tests);
        if (failed_tests == 0 && passed_tests > 1) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: bench/i2c_vectors.txt
# op req_addr slave_addr byte ack stretch twice exp_ack_error exp_data_out (all hex)
# op 0 write 1 read, byte is written or returned, ack 0 NACKs the data, stretch ff is random
0 2a5 2a5 3c 1 00 0 0 00
1 2a5 2a5 c6 1 00 0 0 c6
0 1f0 2a5 81 1 00 0 1 c6
1 1f0 2a5 55 1 00 0 1 c6
0 355 355 a7 1 00 1 0 c6
0 355 355 5e 1 28 0 0 c6
1 0ff 0ff 9b 1 3c 0 0 9b
1 0ff 0ff 24 1 ff 0 0 24
0 3ff 3ff e1 0 00 0 1 24

// File: sources.f
+incdir+logic
logic/i2c_pkg.sv
logic/i2c_line_if.sv
logic/i2c_scl_gen.sv
logic/i2c_shifter.sv
logic/i2c_sequencer.sv
logic/i2c_master_top.sv
bench/i2c_slave_model.sv
bench/tb_i2c_master.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_i2c_master
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
